//--- files.f
design/bpred_pkg.sv
design/prediction_table.sv
design/bht.sv
design/btb.sv
design/branch_predictor.sv
tests/branch_predictor_properties.sv
tests/tb_branch_predictor.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and scans the log for a failure

cd "$(dirname "$0")" || exit 1

top=tb_branch_predictor
log=sim.log

rm -rf obj_dir
if [ $? -ne 0 ]; then
  echo "could not clear obj_dir"
  exit 1
fi

verilator --binary --timing --assert -j 0 --top-module "$top" -f files.f
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

./obj_dir/V$top > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "TEST FAILED" "$log"; then
  echo "failure reported in $log"
  exit 1
fi

if ! grep -q "TEST OK" "$log"; then
  echo "no pass line found in $log"
  exit 1
fi

echo "simulation passed"
exit 0

//--- tests/tb_branch_predictor.sv
`timescale 1ns/1ps

module tb_branch_predictor;

  import bpred_pkg::*;

  localparam int clk_period    = 40;
  localparam int cycle_limit   = 2000;               // About five times the length of all tests
  localparam int random_cycles = 300;

  logic clk;
  logic rst;
  logic fetch_valid;
  pc_t  fetch_pc;
  logic resolve_valid;
  pc_t  resolve_pc;
  logic resolve_taken;
  pc_t  resolve_target;
  logic predict_taken;
  logic predict_hit;
  pc_t  predict_target;
  pc_t  next_pc;

  int     mismatch_count = 0;                        // Wrong output values
  int     other_count    = 0;                        // Other failures
  int     cycle_count    = 0;
  integer seed;

  //////////////////////////////
  // Reference model state
  //////////////////////////////
  counter_t             ref_counter [num_entries];   // 2-bit counters
  logic                 ref_valid   [num_entries];   // BTB slot valid
  logic [tag_width-1:0] ref_tag     [num_entries];
  pc_t                  ref_target  [num_entries];

  branch_predictor u_dut (
    .clk            (clk),
    .rst            (rst),
    .fetch_valid    (fetch_valid),
    .fetch_pc       (fetch_pc),
    .resolve_valid  (resolve_valid),
    .resolve_pc     (resolve_pc),
    .resolve_taken  (resolve_taken),
    .resolve_target (resolve_target),
    .predict_taken  (predict_taken),
    .predict_hit    (predict_hit),
    .predict_target (predict_target),
    .next_pc        (next_pc)
  );

  bind branch_predictor branch_predictor_properties u_props (
    .clk            (clk),
    .rst            (rst),
    .fetch_valid    (fetch_valid),
    .fetch_pc       (fetch_pc),
    .predict_taken  (predict_taken),
    .predict_hit    (predict_hit),
    .predict_target (predict_target),
    .next_pc        (next_pc)
  );

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  // Hang guard
  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= cycle_limit) begin
      $display("timeout: run stopped after %0d cycles", cycle_count);
      $display("TEST FAILED");
      $finish;
    end
  end

  function automatic index_t pc_index(input pc_t pc);
    return pc[4:1];                                  // Halfword aligned
  endfunction

  function automatic logic [tag_width-1:0] pc_tag(input pc_t pc);
    return pc[15:5];
  endfunction

  // Saturating count, up on taken and down on not taken
  function automatic counter_t counter_step(input counter_t cur, input logic taken);
    if (taken) begin
      return (cur == strong_taken) ? strong_taken : counter_t'(cur + 2'd1);
    end
    return (cur == strong_not_taken) ? strong_not_taken : counter_t'(cur - 2'd1);
  endfunction

  task automatic clear_model();
    for (int i = 0; i < num_entries; i++) begin
      ref_counter[i] = strong_not_taken;
      ref_valid[i]   = 1'b0;
      ref_tag[i]     = '0;
      ref_target[i]  = '0;
    end
  endtask

  task automatic train_model(input pc_t pc, input logic taken, input pc_t target);
    index_t idx;
    idx              = pc_index(pc);
    ref_counter[idx] = counter_step(ref_counter[idx], taken);
    if (taken) begin                                 // Only taken outcomes allocate
      ref_valid[idx]  = 1'b1;
      ref_tag[idx]    = pc_tag(pc);
      ref_target[idx] = target;
    end
  endtask

  task automatic check_value(input string name, input pc_t expected, input pc_t actual);
    assert (actual === expected) else begin
      mismatch_count++;
      $display("mismatch at %0t: %s expected %h got %h", $time, name, expected, actual);
    end
  endtask

  // Compares all outputs with the model for the inputs now applied
  task automatic check_outputs();
    index_t idx;
    logic   exp_taken;
    logic   exp_hit;
    pc_t    exp_target;
    pc_t    exp_next;
    idx        = pc_index(fetch_pc);
    exp_taken  = fetch_valid && ref_counter[idx][1];
    exp_hit    = fetch_valid && ref_valid[idx] && (ref_tag[idx] == pc_tag(fetch_pc));
    exp_target = fetch_valid ? ref_target[idx] : '0;  // Disabled read gives zeros
    exp_next   = (exp_taken && exp_hit) ? exp_target : pc_t'(fetch_pc + 16'd2);
    check_value("predict_taken", pc_t'(exp_taken), pc_t'(predict_taken));
    check_value("predict_hit", pc_t'(exp_hit), pc_t'(predict_hit));
    check_value("predict_target", exp_target, predict_target);
    check_value("next_pc", exp_next, next_pc);
  endtask

  // One cycle: drive on the rising edge, check at the falling edge
  task automatic run_cycle(input logic fv, input pc_t fpc, input logic rv,
                           input pc_t rpc, input logic rt, input pc_t rtgt);
    @(posedge clk);
    fetch_valid    <= fv;
    fetch_pc       <= fpc;
    resolve_valid  <= rv;
    resolve_pc     <= rpc;
    resolve_taken  <= rt;
    resolve_target <= rtgt;
    @(negedge clk);
    check_outputs();                                 // Old table contents, no bypass
    if (rv) begin
      train_model(rpc, rt, rtgt);                    // Written at the next edge
    end
  endtask

  //////////////////////////////
  // Directed tests
  //////////////////////////////
  task automatic check_reset_state();
    for (int i = 0; i < num_entries; i++) begin
      run_cycle(1'b1, pc_t'(16'h1000 + 2 * i), 1'b0, '0, 1'b0, '0);
      check_value("predict_taken", '0, pc_t'(predict_taken));
      check_value("predict_hit", '0, pc_t'(predict_hit));
    end
  endtask

  task automatic walk_counter();
    logic [8:0] outcome;
    logic [8:0] expect_taken;
    logic [3:0] seen;
    pc_t        pc;
    outcome      = 9'b110000111;                     // Read from bit 0 up: T T T N N N N T T
    expect_taken = 9'b100001110;                     // Prediction after each outcome
    seen         = 4'b0000;
    pc           = 16'h0246;
    for (int i = 0; i < 9; i++) begin
      run_cycle(1'b0, pc, 1'b1, pc, outcome[i], 16'h0400);
      run_cycle(1'b1, pc, 1'b0, '0, 1'b0, '0);
      seen[u_dut.u_bht.u_table.entries[pc_index(pc)]] = 1'b1; // Counter held by the DUT
      check_value("predict_taken", pc_t'(expect_taken[i]), pc_t'(predict_taken));
    end
    if (seen != 4'b1111) begin
      other_count++;
      $display("counter walk did not pass through all four states");
    end
  endtask

  task automatic probe_btb_tags();
    run_cycle(1'b0, '0, 1'b1, 16'h3a14, 1'b1, 16'h5000); // Allocate, then reach taken
    run_cycle(1'b0, '0, 1'b1, 16'h3a14, 1'b1, 16'h5000);
    run_cycle(1'b1, 16'h3a14, 1'b0, '0, 1'b0, '0);
    check_value("predict_hit", 16'd1, pc_t'(predict_hit));
    check_value("next_pc", 16'h5000, next_pc);
    run_cycle(1'b1, 16'h7a14, 1'b0, '0, 1'b0, '0);   // Same row, other tag
    check_value("predict_hit", 16'd0, pc_t'(predict_hit));
    check_value("next_pc", 16'h7a16, next_pc);
    run_cycle(1'b0, '0, 1'b1, 16'h1234, 1'b0, 16'h6000); // Not taken, same row
    run_cycle(1'b1, 16'h1234, 1'b0, '0, 1'b0, '0);
    check_value("predict_hit", 16'd0, pc_t'(predict_hit));
    run_cycle(1'b1, 16'h3a14, 1'b0, '0, 1'b0, '0);   // Earlier slot still in place
    check_value("predict_hit", 16'd1, pc_t'(predict_hit));
    check_value("predict_target", 16'h5000, predict_target);
    check_value("next_pc", 16'h3a16, next_pc);        // Counter back to weak not taken
  endtask

  task automatic same_cycle_conflict();
    run_cycle(1'b0, '0, 1'b1, 16'h0c08, 1'b1, 16'h0800);
    run_cycle(1'b1, 16'h0c08, 1'b1, 16'h0c08, 1'b1, 16'h0900);
    check_value("predict_taken", 16'd0, pc_t'(predict_taken)); // Still weak not taken
    check_value("predict_target", 16'h0800, predict_target);
    run_cycle(1'b1, 16'h0c08, 1'b0, '0, 1'b0, '0);
    check_value("predict_taken", 16'd1, pc_t'(predict_taken));
    check_value("next_pc", 16'h0900, next_pc);
  endtask

  function automatic logic [tag_width-1:0] pick_tag(input logic [1:0] sel);
    case (sel)
      2'd0:    return 11'h000;
      2'd1:    return 11'h155;
      2'd2:    return 11'h2aa;
      default: return 11'h7ff;
    endcase
  endfunction

  task automatic random_traffic();
    logic [31:0] r;
    pc_t         fpc;
    pc_t         rpc;
    pc_t         tgt;
    for (int i = 0; i < random_cycles; i++) begin
      r   = $random(seed);
      fpc = {pick_tag(r[5:4]), r[9:6], 1'b0};
      rpc = {pick_tag(r[11:10]), r[15:12], 1'b0};
      tgt = pc_t'($random(seed)) & 16'hfffe;         // Aligned targets
      run_cycle(r[0] | r[1], fpc, r[2], rpc, r[3], tgt); // Fetch about 3 in 4
    end
  endtask

  //////////////////////////////
  // Main sequence
  //////////////////////////////
  initial begin
    seed           = 32'h436d;
    rst            = 1'b1;
    fetch_valid    = 1'b0;
    fetch_pc       = '0;
    resolve_valid  = 1'b0;
    resolve_pc     = '0;
    resolve_taken  = 1'b0;
    resolve_target = '0;
    clear_model();
    repeat (3) @(posedge clk);
    rst <= 1'b0;
    check_reset_state();
    walk_counter();
    probe_btb_tags();
    same_cycle_conflict();
    random_traffic();
    run_cycle(1'b0, '0, 1'b0, '0, 1'b0, '0);
    $display("errors: %0d mismatches, %0d other failures", mismatch_count, other_count);
    if (mismatch_count == 0 && other_count == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

//--- tests/branch_predictor_properties.sv
`timescale 1ns/1ps

module branch_predictor_properties (
  input logic           clk,
  input logic           rst,
  input logic           fetch_valid,
  input bpred_pkg::pc_t fetch_pc,
  input logic           predict_taken,
  input logic           predict_hit,
  input bpred_pkg::pc_t predict_target,
  input bpred_pkg::pc_t next_pc
);

  import bpred_pkg::*;

  pc_t seq_pc;                                       // Fall-through address

  assign seq_pc = pc_t'(fetch_pc + 16'd2);

  //////////////////////////////
  // Properties
  //////////////////////////////
  // Tables are empty once reset has been sampled
  property quiet_after_reset;
    @(posedge clk) rst |=> (!predict_taken && !predict_hit);
  endproperty

  // No wordline, no hit
  property no_hit_when_idle;
    @(posedge clk) !fetch_valid |-> !predict_hit;
  endproperty

  // Only two legal sources for the next PC
  property next_pc_source;
    @(posedge clk) (next_pc == seq_pc) || (next_pc == predict_target);
  endproperty

  assert property (quiet_after_reset)
    else $error("prediction active in the cycle after reset");
  assert property (no_hit_when_idle)
    else $error("BTB hit reported while fetch_valid is low");
  assert property (next_pc_source)
    else $error("next_pc is neither fetch_pc plus 2 nor the BTB target");

endmodule

//--- design/branch_predictor.sv
`timescale 1ns/1ps

module branch_predictor (
  input  logic           clk,
  input  logic           rst,                        // Synchronous, active high
  // Fetch side
  input  logic           fetch_valid,                // Lookup request
  input  bpred_pkg::pc_t fetch_pc,                   // Current PC
  // Resolve side, from decode
  input  logic           resolve_valid,              // Outcome strobe
  input  bpred_pkg::pc_t resolve_pc,                 // PC held in IF/ID
  input  logic           resolve_taken,              // Actual direction
  input  bpred_pkg::pc_t resolve_target,             // Actual destination
  // Prediction
  output logic           predict_taken,              // BHT says taken
  output logic           predict_hit,                // BTB holds a target
  output bpred_pkg::pc_t predict_target,             // BTB target
  output bpred_pkg::pc_t next_pc                     // PC to fetch next
);

  import bpred_pkg::*;

  index_t               fetch_index;                 // Fetch row
  logic [tag_width-1:0] fetch_tag;                   // Fetch tag
  index_t               resolve_index;               // Resolve row
  logic [tag_width-1:0] resolve_tag;                 // Resolve tag
  logic                 btb_alloc_en;                // Taken resolves only
  pc_t                  seq_pc;                      // Fall-through address
  logic                 redirect;                    // Use the BTB target

  //////////////////////////////
  // Index and tag split
  //////////////////////////////
  assign fetch_index   = fetch_pc[index_lsb +: index_width];   // Bits 4 to 1
  assign fetch_tag     = fetch_pc[pc_width-1 -: tag_width];    // Bits 15 to 5
  assign resolve_index = resolve_pc[index_lsb +: index_width];
  assign resolve_tag   = resolve_pc[pc_width-1 -: tag_width];

  assign btb_alloc_en  = resolve_valid && resolve_taken; // Not-taken never allocates

  //////////////////////////////
  // Direction and target
  //////////////////////////////
  bht u_bht (
    .clk             (clk),
    .rst             (rst),
    .lookup_en       (fetch_valid),
    .lookup_index    (fetch_index),
    .update_en       (resolve_valid),
    .update_index    (resolve_index),
    .actual_taken    (resolve_taken),
    .predicted_taken (predict_taken)
  );

  btb u_btb (
    .clk          (clk),
    .rst          (rst),
    .lookup_en    (fetch_valid),
    .lookup_index (fetch_index),
    .lookup_tag   (fetch_tag),
    .alloc_en     (btb_alloc_en),
    .alloc_index  (resolve_index),
    .alloc_tag    (resolve_tag),
    .alloc_target (resolve_target),
    .hit          (predict_hit),
    .target       (predict_target)
  );

  //////////////////////////////
  // Next fetch PC
  //////////////////////////////
  // Redirect only when the direction and the target agree
  assign seq_pc   = pc_t'(fetch_pc + pc_step);
  assign redirect = predict_taken && predict_hit;
  assign next_pc  = redirect ? predict_target : seq_pc;

endmodule

//--- design/btb.sv
`timescale 1ns/1ps

module btb (
  input  logic                            clk,
  input  logic                            rst,          // Invalidates all slots
  input  logic                            lookup_en,    // Fetch side valid
  input  bpred_pkg::index_t               lookup_index, // Row for the fetched PC
  input  logic [bpred_pkg::tag_width-1:0] lookup_tag,   // Upper bits of the fetched PC
  input  logic                            alloc_en,     // Taken resolve only
  input  bpred_pkg::index_t               alloc_index,  // Row for the resolved PC
  input  logic [bpred_pkg::tag_width-1:0] alloc_tag,    // Upper bits of the resolved PC
  input  bpred_pkg::pc_t                  alloc_target, // Resolved destination
  output logic                            hit,          // Valid slot with matching tag
  output bpred_pkg::pc_t                  target        // Stored destination
);

  import bpred_pkg::*;

  btb_entry_t lookup_entry;                          // Slot read for fetch
  btb_entry_t alloc_entry;                           // Slot contents to write
  logic       tag_match;                             // Stored tag equals fetch tag

  //////////////////////////////
  // Entry storage
  //////////////////////////////
  // Second read port is not needed here
  prediction_table #(
    .entry_t    (btb_entry_t)
  ) u_table (
    .clk        (clk),
    .rst        (rst),
    .wr_en      (alloc_en),
    .wr_index   (alloc_index),
    .wr_data    (alloc_entry),
    .rd_en_a    (lookup_en),
    .rd_index_a (lookup_index),
    .rd_en_b    (1'b0),                              // Port b idle
    .rd_index_b (index_t'('0)),
    .rd_data_a  (lookup_entry),
    .rd_data_b  ()
  );

  //////////////////////////////
  // Allocation
  //////////////////////////////
  // Direct mapped, a new branch evicts whatever sat in the row
  always_comb begin
    alloc_entry        = '0;
    alloc_entry.valid  = 1'b1;
    alloc_entry.tag    = alloc_tag;
    alloc_entry.target = alloc_target;
  end

  //////////////////////////////
  // Hit detection
  //////////////////////////////
  assign tag_match = (lookup_entry.tag == lookup_tag);
  assign hit       = lookup_entry.valid && tag_match; // Disabled read gives valid low
  assign target    = lookup_entry.target;             // Zero on a disabled read

endmodule

//--- design/bht.sv
`timescale 1ns/1ps

module bht (
  input  logic              clk,
  input  logic              rst,                     // All counters to strong not taken
  input  logic              lookup_en,               // Fetch side valid
  input  bpred_pkg::index_t lookup_index,            // Row for the fetched PC
  input  logic              update_en,               // Resolve side valid
  input  bpred_pkg::index_t update_index,            // Row for the IF/ID PC
  input  logic              actual_taken,            // Resolved direction
  output logic              predicted_taken          // Counter MSB of the fetched row
);

  import bpred_pkg::*;

  counter_t lookup_counter;                          // State seen by fetch
  counter_t update_counter;                          // State of the row being trained
  counter_t next_counter;                            // Value written back

  //////////////////////////////
  // Counter storage
  //////////////////////////////
  // Port a serves fetch, port b reads the row under update
  prediction_table #(
    .entry_t    (counter_t)
  ) u_table (
    .clk        (clk),
    .rst        (rst),
    .wr_en      (update_en),
    .wr_index   (update_index),
    .wr_data    (next_counter),
    .rd_en_a    (lookup_en),
    .rd_index_a (lookup_index),
    .rd_en_b    (update_en),
    .rd_index_b (update_index),
    .rd_data_a  (lookup_counter),
    .rd_data_b  (update_counter)
  );

  assign predicted_taken = lookup_counter[1];        // Upper half of the range is taken

  //////////////////////////////
  // Saturating next state
  //////////////////////////////
  // Training reads the written row, not the fetched one
  always_comb begin
    next_counter = update_counter;
    case (update_counter)
      strong_not_taken: begin
        next_counter = actual_taken ? weak_not_taken : strong_not_taken; // Hold at floor
      end
      weak_not_taken: begin
        next_counter = actual_taken ? weak_taken : strong_not_taken;
      end
      weak_taken: begin
        next_counter = actual_taken ? strong_taken : weak_not_taken;
      end
      strong_taken: begin
        next_counter = actual_taken ? strong_taken : weak_taken;         // Hold at ceiling
      end
      default: begin
        next_counter = strong_not_taken;             // Unreachable with a 2-bit enum
      end
    endcase
  end

endmodule

//--- design/prediction_table.sv
`timescale 1ns/1ps

module prediction_table #(
  parameter type entry_t = bpred_pkg::counter_t      // Payload stored in each row
) (
  input  logic              clk,
  input  logic              rst,                     // Clears every row to zero
  input  logic              wr_en,                   // Write strobe
  input  bpred_pkg::index_t wr_index,                // Row to write
  input  entry_t            wr_data,                 // New row contents
  input  logic              rd_en_a,                 // Read port a enable
  input  bpred_pkg::index_t rd_index_a,              // Read port a row
  input  logic              rd_en_b,                 // Read port b enable
  input  bpred_pkg::index_t rd_index_b,              // Read port b row
  output entry_t            rd_data_a,               // Zero when port a is off
  output entry_t            rd_data_b                // Zero when port b is off
);

  import bpred_pkg::*;

  logic [num_entries-1:0]  wr_wordline;              // One-hot write select
  logic [num_entries-1:0]  rd_wordline_a;            // One-hot read select, port a
  logic [num_entries-1:0]  rd_wordline_b;            // One-hot read select, port b
  entry_t                  entries [num_entries];    // Row registers
  logic [$bits(entry_t)-1:0] bitline_a;              // Wired-OR read bus, port a
  logic [$bits(entry_t)-1:0] bitline_b;              // Wired-OR read bus, port b

  // 4-to-16 decoder gated by an enable
  function automatic logic [num_entries-1:0] decode(input index_t idx, input logic en);
    logic [num_entries-1:0] onehot;
    onehot      = '0;
    onehot[idx] = en;                                // Nothing selected when en is low
    return onehot;
  endfunction

  //////////////////////////////
  // Wordline decoders
  //////////////////////////////
  assign wr_wordline   = decode(wr_index, wr_en);
  assign rd_wordline_a = decode(rd_index_a, rd_en_a);
  assign rd_wordline_b = decode(rd_index_b, rd_en_b);

  //////////////////////////////
  // Row storage
  //////////////////////////////
  always_ff @(posedge clk) begin
    for (int i = 0; i < num_entries; i++) begin
      if (rst) begin
        entries[i] <= entry_t'('0);                  // Strong not taken or invalid
      end else if (wr_wordline[i]) begin
        entries[i] <= wr_data;
      end
    end
  end

  // Each bitline ORs together the rows its wordline enables
  always_comb begin
    bitline_a = '0;
    bitline_b = '0;
    for (int i = 0; i < num_entries; i++) begin
      bitline_a = bitline_a | ({$bits(entry_t){rd_wordline_a[i]}} & entries[i]);
      bitline_b = bitline_b | ({$bits(entry_t){rd_wordline_b[i]}} & entries[i]);
    end
  end

  assign rd_data_a = entry_t'(bitline_a);            // No bypass from the write port
  assign rd_data_b = entry_t'(bitline_b);

endmodule

//--- design/bpred_pkg.sv
package bpred_pkg;

  //////////////////////////////
  // Widths and depths
  //////////////////////////////
  localparam int pc_width    = 16;                   // Instruction address width
  localparam int index_width = 4;                    // Table index width
  localparam int num_entries = 16;                   // Entries per table
  localparam int index_lsb   = 1;                    // Halfword instructions, bit 0 is always 0
  localparam int tag_width   = pc_width - index_width - index_lsb; // PC bits 15 to 5
  localparam int pc_step     = 2;                    // Bytes per instruction

  //////////////////////////////
  // Basic types
  //////////////////////////////
  typedef logic [pc_width-1:0]    pc_t;              // Full PC value
  typedef logic [index_width-1:0] index_t;           // Table row select

  // Saturating 2-bit counter states
  // The MSB doubles as the taken prediction
  typedef enum logic [1:0] {
    strong_not_taken = 2'b00,                        // Reset state
    weak_not_taken   = 2'b01,
    weak_taken       = 2'b10,
    strong_taken     = 2'b11                         // Upper saturation point
  } counter_t;

  //////////////////////////////
  // BTB entry layout
  //////////////////////////////
  // 28 bits in total, all zero means an empty slot
  typedef struct packed {
    logic                 valid;                     // Slot holds a target
    logic [tag_width-1:0] tag;                       // PC bits above the index
    pc_t                  target;                    // Predicted branch destination
  } btb_entry_t;

endpackage
